//--- hw/dot_matrix_pkg.sv
`default_nettype none

package dot_matrix_pkg;

    // panel geometry, fixed by the LED module
    localparam int MATRIX_ROWS = 8;
    localparam int MATRIX_COLS = 8;
    localparam int ROW_IDX_W   = 3;

    localparam int GLYPH_COUNT = 12; // codes 12..15 are blank

    typedef enum logic [3:0] {
        GLYPH_LEVEL0 = 4'd0,
        GLYPH_LEVEL1 = 4'd1,
        GLYPH_LEVEL2 = 4'd2,
        GLYPH_LEVEL3 = 4'd3,
        GLYPH_LEVEL4 = 4'd4,
        GLYPH_FULL   = 4'd5,
        GLYPH_FLAME  = 4'd6,
        GLYPH_STEAM  = 4'd7,
        GLYPH_RING   = 4'd8,
        GLYPH_CHECK  = 4'd9,
        GLYPH_CROSS  = 4'd10,
        GLYPH_ARROW  = 4'd11
    } glyph_t;

    // request seen by the rom, after synchronising and latching
    typedef struct packed {
        glyph_t glyph;
        logic   enable; // synchronised st
        logic   hot;    // synchronised temp
    } frame_req_t;

endpackage

`default_nettype wire

//--- hw/frame_select.sv
`timescale 1ns/1ps
`default_nettype none

module frame_select (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       st,
    input  logic                       temp,
    input  logic [3:0]                 num,
    output dot_matrix_pkg::frame_req_t frame_req
);
    import dot_matrix_pkg::*;

    logic [1:0] st_sync;   // [1] is the stable copy
    logic [1:0] temp_sync;

    // two-flop synchronisers for the asynchronous levels
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            st_sync   <= 2'b00;
            temp_sync <= 2'b00;
        end
        else
        begin
            st_sync   <= {st_sync[0], st};
            temp_sync <= {temp_sync[0], temp};
        end
    end

    // latch stage, num is quasi-static so it is sampled directly
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            frame_req <= '0;
        end
        else
        begin
            frame_req.enable <= st_sync[1];
            frame_req.hot    <= temp_sync[1];
            if (st_sync[1])
            begin
                frame_req.glyph <= glyph_t'(num);
            end
            else
            begin
                frame_req.glyph <= GLYPH_LEVEL0; // display off
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/glyph_rom.sv
`timescale 1ns/1ps
`default_nettype none

module glyph_rom (
    input  logic                                 clk,
    input  logic                                 rst,
    input  dot_matrix_pkg::frame_req_t           frame_req,
    input  logic [dot_matrix_pkg::ROW_IDX_W-1:0] row_idx,
    output logic [dot_matrix_pkg::MATRIX_COLS-1:0] pattern,
    output logic                                 hot_q
);
    import dot_matrix_pkg::*;

    logic [MATRIX_COLS-1:0] bits;

    always_comb
    begin
        bits = '0;
        // blank unless enabled and the code names a real glyph
        if (frame_req.enable && (frame_req.glyph < GLYPH_COUNT))
        begin
            case (frame_req.glyph)
                GLYPH_LEVEL0:
                begin
                    case (row_idx)
                        3'd2, 3'd5: bits = 8'b0001_1000;
                        3'd3, 3'd4: bits = 8'b0011_1100;
                        default:    bits = 8'b0000_0000;
                    endcase
                end
                GLYPH_LEVEL1:
                begin
                    case (row_idx)
                        3'd2, 3'd5: bits = 8'b0011_1000;
                        3'd3, 3'd4: bits = 8'b0111_1100;
                        default:    bits = 8'b0000_0000;
                    endcase
                end
                GLYPH_LEVEL2:
                begin
                    case (row_idx)
                        3'd2, 3'd5: bits = 8'b0011_1100;
                        3'd3, 3'd4: bits = 8'b0111_1110;
                        default:    bits = 8'b0000_0000;
                    endcase
                end
                GLYPH_LEVEL3:
                begin
                    case (row_idx)
                        3'd1, 3'd6:             bits = 8'b0011_1100;
                        3'd2, 3'd3, 3'd4, 3'd5: bits = 8'b0111_1110;
                        default:                bits = 8'b0000_0000;
                    endcase
                end
                GLYPH_LEVEL4:
                begin
                    case (row_idx)
                        3'd0, 3'd7: bits = 8'b0011_1100;
                        3'd1, 3'd6: bits = 8'b0111_1110;
                        default:    bits = 8'b1111_1111; // middle four rows
                    endcase
                end
                GLYPH_FULL:
                begin
                    bits = 8'b1111_1111;
                end
                GLYPH_FLAME:
                begin
                    case (row_idx)
                        3'd0: bits = 8'b1100_0011;
                        3'd1: bits = 8'b1110_0011;
                        3'd2: bits = 8'b1111_0001;
                        3'd3: bits = 8'b1110_0011;
                        3'd4: bits = 8'b1100_0111;
                        3'd5: bits = 8'b1110_0111;
                        3'd6: bits = 8'b1111_0111;
                        3'd7: bits = 8'b1111_1011;
                    endcase
                end
                GLYPH_STEAM:
                begin
                    case (row_idx)
                        3'd1:    bits = 8'b0000_0001;
                        3'd2:    bits = 8'b1000_0001;
                        3'd3:    bits = 8'b1100_0011;
                        3'd4:    bits = 8'b1000_0011;
                        3'd5:    bits = 8'b1100_0111;
                        3'd6:    bits = 8'b1110_0111;
                        3'd7:    bits = 8'b1111_0011;
                        default: bits = 8'b0000_0000;
                    endcase
                end
                GLYPH_RING:
                begin
                    case (row_idx)
                        3'd1, 3'd6:             bits = 8'b0011_1100;
                        3'd2, 3'd3, 3'd4, 3'd5: bits = 8'b0100_0010;
                        default:                bits = 8'b0000_0000;
                    endcase
                end
                GLYPH_CHECK:
                begin
                    case (row_idx)
                        3'd1:    bits = 8'b0000_0001;
                        3'd2:    bits = 8'b0000_0011;
                        3'd3:    bits = 8'b0000_0110;
                        3'd4:    bits = 8'b1000_1100;
                        3'd5:    bits = 8'b1101_1000;
                        3'd6:    bits = 8'b0111_0000;
                        3'd7:    bits = 8'b0010_0000;
                        default: bits = 8'b0000_0000;
                    endcase
                end
                GLYPH_CROSS:
                begin
                    case (row_idx)
                        3'd0, 3'd7: bits = 8'b1000_0001;
                        3'd1, 3'd6: bits = 8'b0100_0010;
                        3'd2, 3'd5: bits = 8'b0010_0100;
                        default:    bits = 8'b0001_1000;
                    endcase
                end
                GLYPH_ARROW:
                begin
                    case (row_idx)
                        3'd0:    bits = 8'b0001_1000;
                        3'd1:    bits = 8'b0011_1100;
                        3'd2:    bits = 8'b0111_1110;
                        3'd3:    bits = 8'b1101_1011;
                        default: bits = 8'b0001_1000; // shaft
                    endcase
                end
                default:
                begin
                    bits = '0;
                end
            endcase
        end
    end

    // colour flag travels with the row it belongs to
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pattern <= '0;
            hot_q   <= 1'b0;
        end
        else
        begin
            pattern <= bits;
            hot_q   <= frame_req.hot;
        end
    end

endmodule

`default_nettype wire

//--- hw/row_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module row_scanner (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [dot_matrix_pkg::MATRIX_COLS-1:0] pattern,
    input  logic                                   hot_q,
    output logic [dot_matrix_pkg::ROW_IDX_W-1:0]   row_idx,
    output logic [dot_matrix_pkg::MATRIX_ROWS-1:0] row,
    output logic [dot_matrix_pkg::MATRIX_COLS-1:0] colg,
    output logic [dot_matrix_pkg::MATRIX_COLS-1:0] colr
);
    import dot_matrix_pkg::*;

    localparam logic [ROW_IDX_W-1:0] LAST_ROW = ROW_IDX_W'(MATRIX_ROWS - 1);

    // free-running row counter, index of the row being prepared
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx <= '0;
        end
        else if (row_idx == LAST_ROW)
        begin
            row_idx <= '0;
        end
        else
        begin
            row_idx <= row_idx + ROW_IDX_W'(1);
        end
    end

    // strobe lags the index by one, same as the rom output
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row <= '1; // no row driven
        end
        else
        begin
            row          <= '1;
            row[row_idx] <= 1'b0;
        end
    end

    assign colg = pattern;
    assign colr = pattern & {MATRIX_COLS{hot_q}}; // red on top of green gives amber

endmodule

`default_nettype wire

//--- hw/dot_matrix_display.sv
`timescale 1ns/1ps
`default_nettype none

module dot_matrix_display (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   st,
    input  logic                                   temp,
    input  logic [3:0]                             num,
    output logic [dot_matrix_pkg::MATRIX_ROWS-1:0] row,
    output logic [dot_matrix_pkg::MATRIX_COLS-1:0] colg,
    output logic [dot_matrix_pkg::MATRIX_COLS-1:0] colr
);
    import dot_matrix_pkg::*;

    frame_req_t             frame_req;
    logic [ROW_IDX_W-1:0]   row_idx;
    logic [MATRIX_COLS-1:0] pattern;
    logic                   hot_q;

    frame_select u_frame_select (
        .clk       (clk),
        .rst       (rst),
        .st        (st),
        .temp      (temp),
        .num       (num),
        .frame_req (frame_req)
    );

    glyph_rom u_glyph_rom (
        .clk       (clk),
        .rst       (rst),
        .frame_req (frame_req),
        .row_idx   (row_idx),
        .pattern   (pattern),
        .hot_q     (hot_q)
    );

    row_scanner u_row_scanner (
        .clk     (clk),
        .rst     (rst),
        .pattern (pattern),
        .hot_q   (hot_q),
        .row_idx (row_idx),
        .row     (row),
        .colg    (colg),
        .colr    (colr)
    );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    localparam int HALF_PERIOD_NS = 10; // 20 ns clock
    localparam int RESET_CYCLES   = 3;

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // release just after an edge so no flop sees it change
    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- verification/dot_matrix_properties.sv
`timescale 1ns/1ps
`default_nettype none

module dot_matrix_properties (
    input logic                                   clk,
    input logic                                   rst,
    input logic [dot_matrix_pkg::MATRIX_ROWS-1:0] row,
    input logic [dot_matrix_pkg::MATRIX_COLS-1:0] colg,
    input logic [dot_matrix_pkg::MATRIX_COLS-1:0] colr
);
    // first strobe appears one cycle after reset is released
    row_one_hot_low: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> $onehot(~row))
        else $error("row strobe is not one-hot low");

    red_inside_green: assert property (@(posedge clk) (colr & ~colg) == '0)
        else $error("red column lit where green is dark");

    dark_when_no_row: assert property (@(posedge clk) (row == '1) |-> (colg == '0))
        else $error("green columns driven with no row selected");

endmodule

bind dot_matrix_display dot_matrix_properties props0 (
    .clk  (clk),
    .rst  (rst),
    .row  (row),
    .colg (colg),
    .colr (colr)
);

`default_nettype wire

//--- verification/tb_dot_matrix_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dot_matrix_display;

    typedef logic [0:7][7:0] frame_t; // row 0 leftmost

    typedef struct packed {
        logic       st;
        logic       temp;
        logic [3:0] num;
        frame_t     green;
    } stim_t;

    localparam int NUM_ENTRIES     = 21;
    localparam int NUM_RANDOM      = 12;
    localparam int CLK_PERIOD_NS   = 20;
    localparam int WATCHDOG_CYCLES = (NUM_ENTRIES + NUM_RANDOM) * 20 + 100;

    logic       clk;
    logic       rst;
    logic       st;
    logic       temp;
    logic [3:0] num;
    logic [7:0] row;
    logic [7:0] colg;
    logic [7:0] colr;

    stim_t  stim_tbl [NUM_ENTRIES];
    int     errors;
    int     checks;
    int     i;
    integer seed;
    integer draw;

    tb_clock_gen clock_gen0 (
        .clk (clk),
        .rst (rst)
    );

    dot_matrix_display dut0 (
        .clk  (clk),
        .rst  (rst),
        .st   (st),
        .temp (temp),
        .num  (num),
        .row  (row),
        .colg (colg),
        .colr (colr)
    );

    task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %s = 8'h%02h, expected 8'h%02h at %0t", name, got, exp, $time);
        end
    endtask

    // expected green bitmaps, blank past code 11
    function automatic frame_t glyph_bitmap(input logic [3:0] code);
        case (code)
            4'd0:    return {8'h00, 8'h00, 8'h18, 8'h3c, 8'h3c, 8'h18, 8'h00, 8'h00};
            4'd1:    return {8'h00, 8'h00, 8'h38, 8'h7c, 8'h7c, 8'h38, 8'h00, 8'h00};
            4'd2:    return {8'h00, 8'h00, 8'h3c, 8'h7e, 8'h7e, 8'h3c, 8'h00, 8'h00};
            4'd3:    return {8'h00, 8'h3c, 8'h7e, 8'h7e, 8'h7e, 8'h7e, 8'h3c, 8'h00};
            4'd4:    return {8'h3c, 8'h7e, 8'hff, 8'hff, 8'hff, 8'hff, 8'h7e, 8'h3c};
            4'd5:    return {8{8'hff}};
            4'd6:    return {8'hc3, 8'he3, 8'hf1, 8'he3, 8'hc7, 8'he7, 8'hf7, 8'hfb};
            4'd7:    return {8'h00, 8'h01, 8'h81, 8'hc3, 8'h83, 8'hc7, 8'he7, 8'hf3};
            4'd8:    return {8'h00, 8'h3c, 8'h42, 8'h42, 8'h42, 8'h42, 8'h3c, 8'h00};
            4'd9:    return {8'h00, 8'h01, 8'h03, 8'h06, 8'h8c, 8'hd8, 8'h70, 8'h20};
            4'd10:   return {8'h81, 8'h42, 8'h24, 8'h18, 8'h18, 8'h24, 8'h42, 8'h81};
            4'd11:   return {8'h18, 8'h3c, 8'h7e, 8'hdb, 8'h18, 8'h18, 8'h18, 8'h18};
            default: return '0;
        endcase
    endfunction

    // entry n < 16 is code n, enabled and cool
    task automatic build_table();
        int n;
        for (n = 0; n < 16; n++)
        begin
            stim_tbl[n] = {1'b1, 1'b0, 4'(n), glyph_bitmap(4'(n))};
        end
        stim_tbl[16] = {1'b1, 1'b1, 4'd5, glyph_bitmap(4'd5)};
        stim_tbl[17] = {1'b1, 1'b1, 4'd6, glyph_bitmap(4'd6)};
        stim_tbl[18] = {1'b1, 1'b1, 4'd11, glyph_bitmap(4'd11)};
        stim_tbl[19] = {1'b0, 1'b0, 4'd5, frame_t'(0)}; // display off
        stim_tbl[20] = {1'b0, 1'b1, 4'd9, frame_t'(0)};
    endtask

    // index of the single low bit, -1 otherwise
    function automatic int low_row_bit(input logic [7:0] r);
        int idx;
        int zeros;
        int b;
        idx   = -1;
        zeros = 0;
        for (b = 0; b < 8; b++)
        begin
            if (r[b] === 1'b0)
            begin
                zeros++;
                idx = b;
            end
        end
        return (zeros == 1) ? idx : -1;
    endfunction

    task automatic apply_entry(input stim_t s);
        int         pos;
        int         prev;
        logic [7:0] exp_row;
        @(posedge clk);
        #1;
        st   = s.st;
        temp = s.temp;
        num  = s.num;
        repeat (8) @(posedge clk); // sync, latch and rom latency
        prev = -1;
        repeat (8)
        begin
            @(negedge clk);
            pos = low_row_bit(row);
            if (pos < 0)
            begin
                errors++;
                $display("row strobe is not one-hot low at %0t, row is %h", $time, row);
            end
            else
            begin
                if (prev >= 0)
                begin
                    exp_row = 8'hff;
                    exp_row[(prev + 1) % 8] = 1'b0;
                    check("row", row, exp_row);
                end
                check("colg", colg, s.green[pos]);
                check("colr", colr, s.temp ? s.green[pos] : 8'h00);
                prev = pos;
            end
        end
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("timeout after %0d cycles, the test sequence never finished", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial
    begin
        st     = 1'b0;
        temp   = 1'b0;
        num    = 4'h0;
        errors = 0;
        checks = 0;
        seed   = 32'h1ca21f34;
        build_table();
        @(posedge clk);
        @(negedge clk); // reset still held here
        check("row", row, 8'hff);
        check("colg", colg, 8'h00);
        check("colr", colr, 8'h00);
        wait (rst == 1'b0);
        for (i = 0; i < NUM_ENTRIES; i++)
        begin
            apply_entry(stim_tbl[i]);
        end
        for (i = 0; i < NUM_RANDOM; i++)
        begin
            draw = $random(seed);
            apply_entry(stim_tbl[draw[3:0]]);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dot_matrix_display.f
hw/dot_matrix_pkg.sv
hw/frame_select.sv
hw/glyph_rom.sv
hw/row_scanner.sv
hw/dot_matrix_display.sv
verification/tb_clock_gen.sv
verification/dot_matrix_properties.sv
verification/tb_dot_matrix_display.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_dot_matrix_display
FILELIST  := dot_matrix_display.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
